// ==== verilog/enc_pkg.sv ====
`default_nettype none

package enc_pkg;

    // ----------------------------------------------------------
    // widths
    // ----------------------------------------------------------
    localparam int cnt_width = 26;                          // one quarter-cycle count
    localparam logic [cnt_width-1:0] cnt_max = '1;          // saturation value, all ones
    localparam int pos_width = 32;                          // signed position count

    // ----------------------------------------------------------
    // apb register map, word aligned on 8-bit paddr
    // ----------------------------------------------------------
    localparam logic [7:0] reg_position = 8'h00;            // r/w, write presets position
    localparam logic [7:0] reg_period   = 8'h04;            // full-cycle period
    localparam logic [7:0] reg_quarter1 = 8'h08;            // newest quarter
    localparam logic [7:0] reg_quarter5 = 8'h0C;            // oldest quarter
    localparam logic [7:0] reg_t_cur    = 8'h10;            // time since last edge
    localparam logic [7:0] reg_status   = 8'h14;            // bit 0 sticky error, w1c

    // edge strobes, a_up in the msb
    typedef struct packed {
        logic a_up;
        logic b_up;
        logic a_down;
        logic b_down;
    } enc_edge_t;

    // one decoded step from the decoder
    typedef struct packed {
        enc_edge_t edges;
        logic      dir;                                     // 0 when a leads b
        logic      valid;                                   // any edge bit set
    } enc_step_t;

    // quarter queue entry
    typedef struct packed {
        logic                 ovf;
        logic                 dir;
        logic                 err;                          // edge out of sequence
        enc_edge_t            edges;
        logic [cnt_width-1:0] count;
    } enc_qtr_t;

    // full-cycle period from quarters 1..4
    typedef struct packed {
        logic                 ovf;
        logic                 dir;
        logic                 dir_change;
        logic                 err;
        logic                 partial;                      // fewer than four edges seen
        logic [cnt_width-1:0] sum;
    } enc_period_t;

endpackage

`default_nettype wire

// ==== verilog/enc_quad_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module enc_quad_decoder
    import enc_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        a,              // encoder line a, async
    input  logic                        b,              // encoder line b, async
    input  logic                        preset,         // one-cycle preset strobe
    input  logic        [pos_width-1:0] preset_value,
    output enc_step_t                   step,
    output logic signed [pos_width-1:0] position,
    output logic                        dir
);

    logic [1:0] a_sync;                                 // two-flop synchronizer
    logic [1:0] b_sync;
    logic       a_prev;                                 // last synchronized level
    logic       b_prev;
    enc_edge_t  edge_now;
    enc_edge_t  edge_r;                                 // edge stage, levels now in *_prev
    logic       dir_next;
    logic       dir_q;
    enc_step_t  step_q;
    logic       single_edge;

    // ----------------------------------------------------------
    // synchronizer and edge detect
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        a_sync <= {a_sync[0], a};
        b_sync <= {b_sync[0], b};
        a_prev <= a_sync[1];
        b_prev <= b_sync[1];
    end

    assign edge_now.a_up   =  a_sync[1] & ~a_prev;
    assign edge_now.b_up   =  b_sync[1] & ~b_prev;
    assign edge_now.a_down = ~a_sync[1] &  a_prev;
    assign edge_now.b_down = ~b_sync[1] &  b_prev;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            edge_r <= '0;
        end else begin
            edge_r <= edge_now;
        end
    end

    // direction from the level of the other line at the edge
    // a leads b: a_up with b low, b_up with a high, a_down with b high, b_down with a low
    always_comb begin
        dir_next = dir_q;                               // hold when idle or on a double edge
        if ($countones(edge_r) == 1) begin
            dir_next = (edge_r.a_up   &  b_prev) | (edge_r.b_up   & ~a_prev)
                     | (edge_r.a_down & ~b_prev) | (edge_r.b_down &  a_prev);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step_q <= '0;
            dir_q  <= 1'b0;
        end else begin
            step_q.edges <= edge_r;
            step_q.dir   <= dir_next;
            step_q.valid <= |edge_r;
            dir_q        <= dir_next;
        end
    end

    // ----------------------------------------------------------
    // position counter, preset wins over a step
    // ----------------------------------------------------------
    assign single_edge = ($countones(step_q.edges) == 1);   // double edge moves nothing

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            position <= '0;
        end else if (preset) begin
            position <= signed'(preset_value);
        end else if (step_q.valid && single_edge) begin
            position <= step_q.dir ? position - 1 : position + 1;
        end
    end

    assign step = step_q;
    assign dir  = dir_q;

    // strobes stay isolated while the pins change at most every other cycle
    a_no_back_to_back: assert property (@(posedge clk) disable iff (!rst_n)
        step_q.valid |=> !step_q.valid);

endmodule

`default_nettype wire

// ==== verilog/enc_period_meter.sv ====
`timescale 1ns/1ps
`default_nettype none

module enc_period_meter
    import enc_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  enc_step_t   step,
    output enc_period_t period,
    output enc_qtr_t    quarter1,
    output enc_qtr_t    quarter5,
    output enc_qtr_t    t_cur
);

    logic [cnt_width-1:0] cnt_q;                        // free-running edge-to-edge counter
    logic                 cnt_ovf;                      // counter reached cnt_max
    logic                 cur_dir;                      // dir of the latest step
    enc_qtr_t             q [1:5];                      // q[1] newest, q[5] oldest
    enc_qtr_t             new_entry;
    enc_edge_t            expect_edge;
    logic [cnt_width+1:0] sum_full;                     // four counts need two extra bits
    logic [3:0]           dirs;
    logic                 sum_ovf;

    // ----------------------------------------------------------
    // sequence check against the previous edge
    // ----------------------------------------------------------
    // dir 0: a_up -> b_up -> a_down -> b_down, rotate right
    // dir 1: a_up -> b_down -> a_down -> b_up, rotate left
    always_comb begin
        if (step.dir) begin
            expect_edge = {q[1].edges[2:0], q[1].edges[3]};
        end else begin
            expect_edge = {q[1].edges[0], q[1].edges[3:1]};
        end
    end

    always_comb begin
        new_entry.ovf   = cnt_ovf;
        new_entry.dir   = step.dir;
        new_entry.err   = (q[1].edges != '0) && (step.edges != expect_edge); // skip on empty q1
        new_entry.edges = step.edges;
        new_entry.count = cnt_q;
    end

    // ----------------------------------------------------------
    // free counter and quarter queue
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_q   <= cnt_max;                         // start saturated
            cnt_ovf <= 1'b1;
            cur_dir <= 1'b0;
            for (int i = 1; i <= 5; i++) begin
                q[i].ovf   <= 1'b1;
                q[i].dir   <= 1'b0;
                q[i].err   <= 1'b0;
                q[i].edges <= '0;                       // empty marker for partial and seq check
                q[i].count <= cnt_max;
            end
        end else if (step.valid) begin
            cnt_q   <= '0;
            cnt_ovf <= 1'b0;
            cur_dir <= step.dir;
            q[1]    <= new_entry;
            for (int i = 2; i <= 5; i++) begin
                q[i] <= q[i-1];
            end
        end else if (cnt_q != cnt_max) begin
            cnt_q <= cnt_q + 1'b1;
        end else begin
            cnt_ovf <= 1'b1;                            // hold at max
        end
    end

    // ----------------------------------------------------------
    // full-cycle period from quarters 1..4
    // ----------------------------------------------------------
    assign sum_full = q[1].count + q[2].count + q[3].count + q[4].count;
    assign sum_ovf  = (sum_full > cnt_max);             // any saturated quarter lands here too
    assign dirs     = {q[1].dir, q[2].dir, q[3].dir, q[4].dir};

    always_comb begin
        period.ovf        = sum_ovf;
        period.dir        = q[1].dir;
        period.dir_change = !((&dirs) || !(|dirs));     // all four must agree
        period.err        = q[1].err | q[2].err | q[3].err | q[4].err;
        period.partial    = (q[4].edges == '0);
        period.sum        = sum_ovf ? cnt_max : sum_full[cnt_width-1:0];
    end

    assign quarter1 = q[1];
    assign quarter5 = q[5];

    // live counter, no edge and no error
    always_comb begin
        t_cur.ovf   = cnt_ovf;
        t_cur.dir   = cur_dir;
        t_cur.err   = 1'b0;
        t_cur.edges = '0;
        t_cur.count = cnt_q;
    end

    // saturated counter holds rather than wrapping
    a_cnt_saturates: assert property (@(posedge clk) disable iff (!rst_n)
        (cnt_q == cnt_max && !step.valid) |=> (cnt_q == cnt_max && cnt_ovf));

    // queue moves only on a decoder strobe
    a_shift_on_step: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(q[2]) |-> $past(step.valid));

endmodule

`default_nettype wire

// ==== verilog/enc_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module enc_apb_regs
    import enc_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic                  [7:0] paddr,
    input  logic                 [31:0] pwdata,
    output logic                 [31:0] prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  enc_step_t                   step,
    input  logic signed [pos_width-1:0] position,
    input  enc_period_t                 period,
    input  enc_qtr_t                    quarter1,
    input  enc_qtr_t                    quarter5,
    input  enc_qtr_t                    t_cur,
    output logic                        preset,
    output logic        [pos_width-1:0] preset_value
);

    logic access;                                       // apb access phase
    logic pready_q;                                     // armed in setup phase
    logic addr_ok;
    logic addr_ro;
    logic wr_en;                                        // accepted write
    logic err_sticky;
    logic preset_q;
    logic [pos_width-1:0] preset_value_q;

    // quarter word: ovf, dir, edge mask, count
    function automatic logic [31:0] pack_qtr(enc_qtr_t e);
        return {e.ovf, e.dir, e.edges, e.count};
    endfunction

    // ----------------------------------------------------------
    // apb handshake, no wait states
    // ----------------------------------------------------------
    assign access = psel & penable;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pready_q <= 1'b0;
        end else begin
            pready_q <= psel & ~penable;                // high for the following access phase
        end
    end

    assign pready = pready_q;

    always_comb begin
        addr_ok = 1'b1;
        addr_ro = 1'b1;
        case (paddr)
            reg_position, reg_status: addr_ro = 1'b0;
            reg_period, reg_quarter1, reg_quarter5, reg_t_cur: addr_ro = 1'b1;
            default: addr_ok = 1'b0;                    // unmapped
        endcase
    end

    assign pslverr = pready_q & (~addr_ok | (pwrite & addr_ro));
    assign wr_en   = access & pwrite & addr_ok & ~addr_ro;   // bad writes change nothing

    // ----------------------------------------------------------
    // preset strobe and sticky status
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            preset_q   <= 1'b0;
            err_sticky <= 1'b0;
        end else begin
            preset_q <= wr_en && (paddr == reg_position);
            if (step.valid && $countones(step.edges) > 1) begin
                err_sticky <= 1'b1;                     // both lines moved together
            end else if (wr_en && (paddr == reg_status) && pwdata[0]) begin
                err_sticky <= 1'b0;                     // write 1 to clear
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && (paddr == reg_position)) begin
            preset_value_q <= pwdata;
        end
    end

    assign preset       = preset_q;
    assign preset_value = preset_value_q;

    // live read mux
    always_comb begin
        case (paddr)
            reg_position: prdata = unsigned'(position);
            reg_period:   prdata = {period.ovf, period.dir, period.dir_change, period.err,
                                    period.partial, 1'b0, period.sum};
            reg_quarter1: prdata = pack_qtr(quarter1);
            reg_quarter5: prdata = pack_qtr(quarter5);
            reg_t_cur:    prdata = pack_qtr(t_cur);
            reg_status:   prdata = {31'b0, err_sticky};
            default:      prdata = '0;
        endcase
    end

    // ready only inside a proper access phase from the master
    a_pready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        pready |-> (psel && penable));

endmodule

`default_nettype wire

// ==== verilog/enc_channel_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module enc_channel_top
    import enc_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        a,
    input  logic        b,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic  [7:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    enc_step_t                   step;                  // decoder strobe to meter and regs
    enc_period_t                 period;
    enc_qtr_t                    quarter1;
    enc_qtr_t                    quarter5;
    enc_qtr_t                    t_cur;
    logic signed [pos_width-1:0] position;
    logic                        preset;
    logic        [pos_width-1:0] preset_value;

    // ----------------------------------------------------------
    // decoder, meter, register block
    // ----------------------------------------------------------
    enc_quad_decoder u_decoder (
        .clk, .rst_n, .a, .b,
        .preset, .preset_value,
        .step, .position,
        .dir          ()                                // meter keeps its own copy from step
    );

    enc_period_meter u_meter (
        .clk, .rst_n, .step,
        .period, .quarter1, .quarter5, .t_cur
    );

    enc_apb_regs u_regs (
        .clk, .rst_n,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .step, .position, .period, .quarter1, .quarter5, .t_cur,
        .preset, .preset_value
    );

endmodule

`default_nettype wire

// ==== sim/enc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module enc_tb
    import enc_pkg::*;
();

    localparam int settle_cycles = 6;                   // pin change to updated queue and position
    localparam int apb_timeout   = 8;
    localparam int drain_timeout = 20;

    logic        clk;
    logic        rst_n;
    logic        a;
    logic        b;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic  [7:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int          cycle = 0;                             // free cycle count for edge spacing
    int          last_change = -1;                      // -1 until the first edge after reset
    int          exp_pos = 0;
    logic        cur_dir = 1'b0;
    int          gaps_q [$];                            // cycles since previous pin change
    logic        dirs_q [$];
    logic [3:0]  masks_q [$];
    logic [31:0] q1_hist [$];
    logic [31:0] lfsr_state = 32'ha393_b0b7;

    // pending checks, filled by stimulus and drained by the compare process
    string       chk_name [$];
    logic [31:0] chk_got [$];
    logic [31:0] chk_exp [$];
    time         chk_time [$];
    string       cmp_name;
    logic [31:0] cmp_got;
    logic [31:0] cmp_exp;
    time         cmp_time;
    int          checks = 0;
    int          value_errors = 0;
    int          other_errors = 0;

    enc_channel_top uut (
        .clk, .rst_n, .a, .b,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // ----------------------------------------------------------
    // reference model
    // ----------------------------------------------------------
    // edge that must follow e for direction d, one-hot {a_up, b_up, a_down, b_down}
    function automatic logic [3:0] next_edge(input logic [3:0] e, input logic d);
        case (e)
            4'b1000: return d ? 4'b0001 : 4'b0100;     // after a_up
            4'b0100: return d ? 4'b1000 : 4'b0010;     // after b_up
            4'b0010: return d ? 4'b0100 : 4'b0001;     // after a_down
            4'b0001: return d ? 4'b0010 : 4'b1000;     // after b_down
            default: return 4'b0000;                    // double edge has no successor
        endcase
    endfunction

    function automatic logic [31:0] qtr_word(input enc_qtr_t e);
        return {e.ovf, e.dir, e.edges, e.count};
    endfunction

    // returns {period, quarter1, quarter5} words after replaying every edge since reset
    function automatic logic [95:0] expected_period(input int gaps[$], input logic dirs[$],
                                                    input logic [3:0] masks[$]);
        enc_qtr_t    q [1:5];
        enc_qtr_t    e;
        logic [27:0] total;
        logic        same_dir;
        logic [31:0] pw;
        for (int k = 1; k <= 5; k++) begin
            q[k].ovf   = 1'b1;
            q[k].dir   = 1'b0;
            q[k].err   = 1'b0;
            q[k].edges = 4'b0000;
            q[k].count = cnt_max;
        end
        for (int i = 0; i < gaps.size(); i++) begin
            if (gaps[i] < 0 || gaps[i] - 1 >= int'(cnt_max)) begin
                e.count = cnt_max;                      // counter still saturated
                e.ovf   = 1'b1;
            end else begin
                e.count = gaps[i] - 1;
                e.ovf   = 1'b0;
            end
            e.dir   = dirs[i];
            e.edges = masks[i];
            e.err   = (q[1].edges != 4'b0000) && (masks[i] != next_edge(q[1].edges, dirs[i]));
            for (int k = 5; k >= 2; k--) begin
                q[k] = q[k-1];
            end
            q[1] = e;
        end
        total    = q[1].count + q[2].count + q[3].count + q[4].count;
        same_dir = (q[1].dir == q[2].dir) && (q[2].dir == q[3].dir) && (q[3].dir == q[4].dir);
        pw[31]    = (total > cnt_max);
        pw[30]    = q[1].dir;
        pw[29]    = !same_dir;
        pw[28]    = q[1].err | q[2].err | q[3].err | q[4].err;
        pw[27]    = (q[4].edges == 4'b0000);           // queue not yet filled
        pw[26]    = 1'b0;
        pw[25:0]  = (total > cnt_max) ? cnt_max : total[25:0];
        return {pw, qtr_word(q[1]), qtr_word(q[5])};
    endfunction

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | lfsr_state[0];               // one step per bit
        end
    endtask

    // ----------------------------------------------------------
    // compare process
    // ----------------------------------------------------------
    task automatic expect_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_name.push_back(name);
        chk_got.push_back(got);
        chk_exp.push_back(exp);
        chk_time.push_back($time);
    endtask

    always @(posedge clk) begin
        while (chk_name.size() > 0) begin
            cmp_name = chk_name.pop_front();
            cmp_got  = chk_got.pop_front();
            cmp_exp  = chk_exp.pop_front();
            cmp_time = chk_time.pop_front();
            checks++;
            if (cmp_got !== cmp_exp) begin
                $display("[FAIL] t=%0t %s got 0x%08h expected 0x%08h",
                         cmp_time, cmp_name, cmp_got, cmp_exp);
                value_errors++;
            end
        end
    end

    // ----------------------------------------------------------
    // apb and encoder drivers
    // ----------------------------------------------------------
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            input logic exp_err, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        psel    = 1'b1;                                 // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;                                 // access phase
        #4;
        while (!pready && waited < apb_timeout) begin
            @(posedge clk);
            #5;
            waited++;
        end
        if (!pready) begin
            $display("t=%0t APB access to 0x%02h never saw pready", $time, addr);
            other_errors++;
        end
        rdata = prdata;
        expect_word("pslverr", {31'b0, pslverr}, {31'b0, exp_err});
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_check(input logic [7:0] addr, input string name,
                              input logic [31:0] exp, output logic [31:0] got);
        apb_xfer(1'b0, addr, 32'h0, 1'b0, got);
        expect_word(name, got, exp);
    endtask

    // one pin change in direction d, or both lines at once, n cycles after the call
    task automatic drive_edge(input logic d, input logic both, input int n);
        logic       na;
        logic       nb;
        logic [3:0] m;
        repeat (n) @(posedge clk);
        #1;
        na = a;
        nb = b;
        if (both) begin
            na = ~a;
            nb = ~b;
        end else if ((a == b) != d) begin
            na = ~a;
        end else begin
            nb = ~b;
        end
        m = {na & ~a, nb & ~b, ~na & a, ~nb & b};
        gaps_q.push_back((last_change < 0) ? -1 : cycle - last_change);
        masks_q.push_back(m);
        if (!both) begin
            cur_dir = d;
            exp_pos = exp_pos + (d ? -1 : 1);
        end
        dirs_q.push_back(cur_dir);                      // double edge keeps the old dir
        last_change = cycle;
        a = na;
        b = nb;
    endtask

    // position, period and both quarters against the reference
    task automatic check_channel(output logic [31:0] q1_read);
        logic [95:0] r;
        logic [31:0] got;
        repeat (settle_cycles) @(posedge clk);          // last edge through decoder and queue
        r = expected_period(gaps_q, dirs_q, masks_q);
        read_check(reg_position, "position", exp_pos, got);
        read_check(reg_period, "period", r[95:64], got);
        read_check(reg_quarter1, "quarter1", r[63:32], q1_read);
        read_check(reg_quarter5, "quarter5", r[31:0], got);
    endtask

    // ----------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------
    initial begin
        logic [31:0] rd;
        int          n;
        int          r;
        rst_n   = 1'b0;
        a       = 1'b0;
        b       = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'h00;
        pwdata  = 32'h0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // after reset: saturated quarters, partial period
        check_channel(rd);
        read_check(reg_t_cur, "t_cur", {1'b1, 1'b0, 4'b0000, cnt_max}, rd);

        // forward at constant random spacing
        random_bits(6, r);
        n = 8 + r % 33;
        for (int i = 0; i < 8; i++) begin
            drive_edge(1'b0, 1'b0, n);
        end
        check_channel(rd);
        read_check(reg_period, "period sum", {5'b00000, 1'b0, 26'(4 * (n - 1))}, rd);

        // reversal, one edge at a time
        random_bits(6, r);
        n = 8 + r % 33;
        for (int k = 1; k <= 6; k++) begin
            drive_edge(1'b1, 1'b0, n);
            check_channel(rd);
            q1_hist.push_back(rd);
            apb_xfer(1'b0, reg_period, 32'h0, 1'b0, rd);
            expect_word("period dir", {31'b0, rd[30]}, 32'd1);
            expect_word("period dir_change", {31'b0, rd[29]}, {31'b0, k < 4});
            if (k >= 5) begin
                read_check(reg_quarter5, "quarter5 vs earlier quarter1", q1_hist[k-5], rd);
            end
        end

        // both lines together
        drive_edge(cur_dir, 1'b1, 10);
        check_channel(rd);
        read_check(reg_status, "status", 32'd1, rd);
        apb_xfer(1'b0, reg_period, 32'h0, 1'b0, rd);
        expect_word("period err", {31'b0, rd[28]}, 32'd1);

        // preset and bus errors, sticky status still set so a stray clear shows
        apb_xfer(1'b1, reg_position, 32'h8000_1234, 1'b0, rd);
        exp_pos = 32'h8000_1234;
        read_check(reg_position, "position", exp_pos, rd);
        apb_xfer(1'b0, 8'h18, 32'h0, 1'b1, rd);         // unmapped read
        apb_xfer(1'b1, 8'h20, 32'h5555_aaab, 1'b1, rd); // unmapped write
        apb_xfer(1'b1, reg_period, 32'hffff_ffff, 1'b1, rd); // read-only register
        check_channel(rd);
        read_check(reg_status, "status", 32'd1, rd);

        // write 1 clears the sticky error
        apb_xfer(1'b1, reg_status, 32'd1, 1'b0, rd);
        read_check(reg_status, "status", 32'd0, rd);

        r = 0;
        while (chk_name.size() > 0 && r < drain_timeout) begin
            @(posedge clk);
            r++;
        end
        #1;
        if (chk_name.size() > 0) begin
            $display("compare queue still held %0d checks at the end", chk_name.size());
            other_errors++;
        end
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/enc_pkg.sv
verilog/enc_quad_decoder.sv
verilog/enc_period_meter.sv
verilog/enc_apb_regs.sv
verilog/enc_channel_top.sv
sim/enc_tb.sv
